// File: compile.f
hw/shuffle_pkg.sv
hw/bank_ram.sv
hw/bank_array.sv
hw/write_ctrl.sv
hw/read_ctrl.sv
hw/skid_buffer.sv
hw/inner_shuffle.sv
testbench/tb_inner_shuffle.sv

// File: run.sh
#!/bin/sh
# Build and run the transposer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_inner_shuffle \
	-f compile.f \
	-o tb_inner_shuffle

# The log decides the result, the simulator status may be lost in the pipe
./obj_dir/tb_inner_shuffle 2>&1 | tee sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// File: testbench/tb_inner_shuffle.sv
`timescale 1ns/100ps

module tb_inner_shuffle import shuffle_pkg::*; ();

	localparam int timeout_cycles = 2000;	// Per wait loop
	localparam int mat_elems = rows * cols;
	localparam int row_blocks = rows / simd;	// Output beats per column

	logic      clk = 1'b0;
	logic      rst;
	lane_vec_t idat;
	logic      ivld;
	logic      irdy;
	lane_vec_t odat;
	logic      ovld;
	logic      ordy;

	lane_vec_t exp_q [$];	// Reference model output, in order
	lane_vec_t out_q [$];	// Beats seen on the output
	int        error_cnt = 0;
	int        in_cnt = 0;	// Input transfers since reset
	int        out_cnt = 0;	// Output transfers since reset
	int        overlap_by_mat [16];	// Edges where matrix m leaves while m+1 enters
	logic      hold_pend = 1'b0;
	lane_vec_t hold_data;

	always #5 clk = ~clk;

	inner_shuffle inner_shuffle_inst (
		.clk  (clk),
		.rst  (rst),
		.idat (idat),
		.ivld (ivld),
		.irdy (irdy),
		.odat (odat),
		.ovld (ovld),
		.ordy (ordy)
	);

	// ------------------------------------------------------------------------
	// Checker and output monitor
	// ------------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			error_cnt++;
		end
	endtask

	// Values read here are the ones held just before the edge
	always @(posedge clk) begin
		if (rst) begin
			hold_pend = 1'b0;
		end else begin
			if (hold_pend) begin	// Stalled last cycle
				check_value("ovld under back-pressure", ovld, 1);
				check_value("odat under back-pressure", odat, hold_data);
			end
			hold_pend = ovld && !ordy;
			hold_data = odat;
			if (ovld && ordy) begin
				if (ivld && irdy && (in_cnt / page_beats == out_cnt / page_beats + 1) &&
					(out_cnt / page_beats < 16)) begin
					overlap_by_mat[out_cnt / page_beats]++;
				end
				out_q.push_back(odat);
				out_cnt++;
			end
			if (ivld && irdy) begin
				in_cnt++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus and reference model
	// ------------------------------------------------------------------------
	task automatic apply_reset();
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
	endtask

	// Random matrices enter row-major and the expected beats queue up column by column
	task automatic send_matrices(input int n, input bit gaps);
		elem_t     mat [mat_elems];
		lane_vec_t beat;
		lane_vec_t expb;
		int        waited;
		for (int m = 0; m < n; m++) begin
			for (int i = 0; i < mat_elems; i++) begin
				mat[i] = elem_t'($urandom);
			end
			for (int c = 0; c < cols; c++) begin
				for (int b = 0; b < row_blocks; b++) begin
					for (int s = 0; s < simd; s++) begin
						expb[s] = mat[(simd * b + s) * cols + c];	// Row 4b+s, column c
					end
					exp_q.push_back(expb);
				end
			end
			for (int k = 0; k < page_beats; k++) begin
				if (gaps && ($urandom % 3 == 0)) begin
					ivld <= 1'b0;
					repeat (1 + $urandom % 3) @(posedge clk);	// Idle gap
				end
				for (int s = 0; s < simd; s++) begin
					beat[s] = mat[simd * k + s];
				end
				idat <= beat;
				ivld <= 1'b1;
				waited = 0;
				@(posedge clk);
				while (!irdy && waited < timeout_cycles) begin
					@(posedge clk);
					waited++;
				end
				if (!irdy) begin
					$display("Timeout at %0t: input beat %0d never accepted", $time, k);
					error_cnt++;
				end
			end
		end
		ivld <= 1'b0;
	endtask

	// Random low periods of ordy until n beats have left
	task automatic toggle_ready(input int n);
		int waited;
		waited = 0;
		while (out_q.size() < n && waited < 4 * timeout_cycles) begin
			@(posedge clk);
			ordy <= ($urandom % 3) != 0;
			waited++;
		end
		if (out_q.size() < n) begin
			$display("Timeout at %0t: output stalled during random ordy", $time);
			error_cnt++;
		end
		ordy <= 1'b1;
	endtask

	task automatic compare_outputs(input int n);
		int        waited;
		lane_vec_t got;
		lane_vec_t exp;
		waited = 0;
		while (out_q.size() < n && waited < timeout_cycles) begin
			@(posedge clk);
			waited++;
		end
		if (out_q.size() < n) begin
			$display("Timeout at %0t: only %0d of %0d output beats arrived",
				$time, out_q.size(), n);
			error_cnt++;
		end
		for (int i = 0; i < n; i++) begin
			if (out_q.size() == 0 || exp_q.size() == 0) begin
				break;
			end
			got = out_q.pop_front();
			exp = exp_q.pop_front();
			check_value($sformatf("odat beat %0d", i), got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic reset_state_check();
		check_value("irdy after reset", irdy, 1);
		check_value("ovld after reset", ovld, 0);
	endtask

	task automatic single_matrix();
		ordy <= 1'b1;
		send_matrices(1, 1'b0);
		compare_outputs(page_beats);
	endtask

	task automatic back_to_back();
		int base;
		base = out_cnt / page_beats;	// Global index of the first matrix here
		ordy <= 1'b1;
		send_matrices(4, 1'b0);
		compare_outputs(4 * page_beats);
		for (int m = base; m < base + 3; m++) begin
			check_value($sformatf("overlap after matrix %0d", m), overlap_by_mat[m] > 0, 1);
		end
	endtask

	task automatic random_stalls();
		fork
			send_matrices(3, 1'b1);
			toggle_ready(3 * page_beats);
		join
		compare_outputs(3 * page_beats);
	endtask

	// Both pages fill while nothing drains
	task automatic full_backpressure();
		int waited;
		ordy <= 1'b0;
		send_matrices(2, 1'b0);
		@(posedge clk);	// Second page flag rises on the edge after the last write
		check_value("irdy with both pages full", irdy, 0);
		ordy <= 1'b1;
		compare_outputs(2 * page_beats);
		waited = 0;
		while (!irdy && waited < timeout_cycles) begin
			@(posedge clk);
			waited++;
		end
		check_value("irdy after drain", irdy, 1);
	endtask

	initial begin
		void'($urandom(32'h134ae74c));
		rst <= 1'b1;
		ivld <= 1'b0;
		idat <= '0;
		ordy <= 1'b0;
		apply_reset();
		reset_state_check();
		single_matrix();
		back_to_back();
		random_stalls();
		full_backpressure();
		check_value("leftover output beats", out_q.size(), 0);
		check_value("missing output beats", exp_q.size(), 0);
		$display("Simulation done, %0d errors", error_cnt);
		if (error_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: hw/inner_shuffle.sv
`timescale 1ns/100ps

module inner_shuffle import shuffle_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// Input stream, row-major
	input  lane_vec_t idat,
	input  logic      ivld,
	output logic      irdy,
	// Output stream, column by column
	output lane_vec_t odat,
	output logic      ovld,
	input  logic      ordy
);

	// Write side to bank array
	logic           wr_en;
	bank_addr_t     wr_addr;
	lane_vec_t      wr_data;
	// Page handshake between controllers
	logic [1:0]     page_full;
	logic           page_release;
	// Read side
	logic           rd_en;
	bank_addr_vec_t rd_addr;
	bank_sel_vec_t  rd_pat;
	lane_vec_t      rd_data;
	logic           rd_vld;
	logic           fill_ok;	// Registered ready from the skid buffer

	// ------------------------------------------------------------------------
	// Controllers
	// ------------------------------------------------------------------------
	write_ctrl write_ctrl_inst (
		.clk          (clk),
		.rst          (rst),
		.ivld         (ivld),
		.idat         (idat),
		.page_release (page_release),
		.irdy         (irdy),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.page_full    (page_full)
	);

	read_ctrl read_ctrl_inst (
		.clk          (clk),
		.rst          (rst),
		.page_full    (page_full),
		.fill_ok      (fill_ok),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_pat       (rd_pat),
		.page_release (page_release)
	);

	// ------------------------------------------------------------------------
	// Storage and output stage
	// ------------------------------------------------------------------------
	bank_array bank_array_inst (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_pat  (rd_pat),
		.fill_ok (fill_ok),
		.rd_data (rd_data),
		.rd_vld  (rd_vld)
	);

	skid_buffer skid_buffer_inst (
		.clk      (clk),
		.rst      (rst),
		.in_data  (rd_data),
		.in_vld   (rd_vld),
		.fill_ok  (fill_ok),
		.out_data (odat),
		.out_vld  (ovld),
		.out_rdy  (ordy)	// Only path from ordy, ends in registers
	);

endmodule

// File: hw/skid_buffer.sv
`timescale 1ns/100ps

module skid_buffer import shuffle_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// Upstream, from the bank read stage
	input  lane_vec_t in_data,
	input  logic      in_vld,
	output logic      fill_ok,	// Registered, skid slot free
	// Downstream output stream
	output lane_vec_t out_data,
	output logic      out_vld,
	input  logic      out_rdy
);

	lane_vec_t skid_data;	// Beat caught while out_rdy was low
	logic push;
	logic load_main;	// Incoming beat goes straight to the output
	logic load_skid;	// Incoming beat parks in the skid slot
	logic unskid;	// Skid slot moves to the output

	assign push = in_vld && fill_ok;
	assign load_main = push && (!out_vld || out_rdy);
	assign load_skid = push && out_vld && !out_rdy;
	assign unskid = !fill_ok && out_rdy;	// Skid full implies out_vld

	// ------------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			out_vld <= 1'b0;
			fill_ok <= 1'b1;
		end else begin
			if (load_main) begin
				out_vld <= 1'b1;
			end else if (fill_ok && out_rdy) begin
				out_vld <= 1'b0;	// Drained with nothing behind it
			end
			if (load_skid) begin
				fill_ok <= 1'b0;
			end else if (unskid) begin
				fill_ok <= 1'b1;
			end
		end
	end

	// Data path
	always_ff @(posedge clk) begin
		if (load_main) begin
			out_data <= in_data;
		end else if (unskid) begin
			out_data <= skid_data;
		end
		if (load_skid) begin
			skid_data <= in_data;
		end
	end

	a_hold_out: assert property (
		@(posedge clk) disable iff (rst)
		(out_vld && !out_rdy) |=> (out_vld && $stable(out_data))
	) else $error("skid_buffer output changed under back-pressure");

endmodule

// File: hw/read_ctrl.sv
`timescale 1ns/100ps

module read_ctrl import shuffle_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  logic [1:0]     page_full,	// Pages ready to be read
	input  logic           fill_ok,	// Output side has room
	output logic           rd_en,
	output bank_addr_vec_t rd_addr,	// One address per bank
	output bank_sel_vec_t  rd_pat,	// Bank for each output lane
	output logic           page_release	// Last read of a page issued
);

	logic [$clog2(rd_rot_period+1)-1:0] blk_cnt;	// Row block, simd rows each
	logic [$clog2(cols)-1:0] col_cnt;	// Output column
	logic cur_page;	// Page being read
	logic blk_last;
	logic col_last;
	logic page_boundary;
	logic [simd-1:0] hor_inc;	// Row word steps when the column moves on
	bank_addr_t vert_inc;
	bank_addr_t col_dec;
	bank_addr_t next_base;	// Start of the page read next
	bank_sel_t col_ofs;	// Column modulo bank count
	bank_addr_vec_t lane_addr_q;	// Address of each row lane, last read
	bank_addr_vec_t lane_addr;	// Address of each row lane, this read
	bank_sel_vec_t pat_nxt;

	assign rd_en = page_full[cur_page] && fill_ok;
	assign blk_last = (blk_cnt == rd_rot_period - 1);
	assign col_last = (col_cnt == cols - 1);
	assign page_boundary = blk_last && col_last;
	assign page_release = rd_en && page_boundary;

	// ------------------------------------------------------------------------
	// Output loop, columns outer and row blocks inner
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			blk_cnt <= '0;
			col_cnt <= '0;
			cur_page <= 1'b0;
		end else if (rd_en) begin
			blk_cnt <= blk_last ? '0 : blk_cnt + 1'b1;
			if (blk_last) begin
				col_cnt <= col_last ? '0 : col_cnt + 1'b1;
			end
			if (page_boundary) begin
				cur_page <= !cur_page;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Address generation
	// ------------------------------------------------------------------------
	// Next block is cols words further down, a new column rewinds to block 0
	assign vert_inc = (blk_cnt != 0) ? bank_addr_t'(cols) : '0;
	assign col_dec = (blk_cnt == 0 && col_cnt != 0) ?
		bank_addr_t'((rd_rot_period - 1) * cols) : '0;
	assign next_base = cur_page ? '0 : bank_addr_t'(page_beats);

	always_comb begin
		for (int s = 0; s < simd; s++) begin
			// Row s crosses a word boundary when (s*cols + col) hits a multiple of simd
			hor_inc[s] = (blk_cnt == 0) && (col_cnt != 0) &&
				(((col_cnt + s * (cols % simd)) % simd) == 0);
			lane_addr[s] = lane_addr_q[s] + bank_addr_t'(hor_inc[s]) + vert_inc - col_dec;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lane_addr_q <= rd_addr_init;	// Page 0
		end else if (rd_en) begin
			if (page_boundary) begin
				for (int s = 0; s < simd; s++) begin
					lane_addr_q[s] <= rd_addr_init[s] + next_base;
				end
			end else begin
				lane_addr_q <= lane_addr;
			end
		end
	end

	// Crossbar, bank b serves the lane whose pattern entry is b
	assign col_ofs = bank_sel_t'(col_cnt % simd);

	always_comb begin
		for (int b = 0; b < simd; b++) begin
			rd_addr[b] = lane_addr[rev_rd_init_pat[(simd + b - int'(col_ofs)) % simd]];
		end
	end

	// ------------------------------------------------------------------------
	// Read pattern, one step per column
	// ------------------------------------------------------------------------
	always_comb begin
		for (int s = 0; s < simd; s++) begin
			pat_nxt[s] = rd_pat[rev_rd_perm_pat[s]];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_pat <= rd_init_pat;
		end else if (rd_en) begin
			if (page_boundary) begin
				rd_pat <= rd_init_pat;	// Restart for the next matrix
			end else if (blk_last) begin
				rd_pat <= pat_nxt;	// Every rd_rot_period reads
			end
		end
	end

endmodule

// File: hw/write_ctrl.sv
`timescale 1ns/100ps

module write_ctrl import shuffle_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	// Input stream
	input  logic       ivld,
	input  lane_vec_t  idat,
	output logic       irdy,
	// Oldest full page has been read out
	input  logic       page_release,
	// Bank write port
	output logic       wr_en,
	output bank_addr_t wr_addr,
	output lane_vec_t  wr_data,
	output logic [1:0] page_full	// One flag per page
);

	logic [$clog2(wr_rot_period+1)-1:0] rep_cnt;	// Beats at the current offset
	logic [$clog2(wr_rotations+1)-1:0]  rot_cnt;	// Current lane offset
	logic rotate;	// Last beat before the offset moves
	logic wr_page;	// Page being filled
	logic page_end;	// Last word of either page
	logic rel_page;	// Page freed by the next release

	assign irdy = ~&page_full;	// Stall only with both pages waiting
	assign wr_en = ivld && irdy;
	assign wr_page = (wr_addr >= bank_addr_t'(page_beats));
	assign page_end = (wr_addr == bank_addr_t'(page_beats - 1)) ||
		(wr_addr == bank_addr_t'(bank_depth - 1));
	assign rotate = (rep_cnt == wr_rot_period - 1);

	// ------------------------------------------------------------------------
	// Write address and lane rotation
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_addr <= '0;
			rep_cnt <= '0;
			rot_cnt <= '0;
		end else if (wr_en) begin
			wr_addr <= (wr_addr == bank_addr_t'(bank_depth - 1)) ? '0 : wr_addr + 1'b1;
			rep_cnt <= rotate ? '0 : rep_cnt + 1'b1;
			if (rotate) begin
				// Offset cycles through gcd(cols, simd) values
				rot_cnt <= (rot_cnt == wr_rotations - 1) ? '0 : rot_cnt + 1'b1;
			end
		end
	end

	// Bank b takes the lane rot_cnt places to its left
	always_comb begin
		for (int b = 0; b < simd; b++) begin
			wr_data[b] = idat[(simd + b - int'(rot_cnt)) % simd];
		end
	end

	// ------------------------------------------------------------------------
	// Page flags
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			page_full <= 2'b00;
			rel_page <= 1'b0;
		end else begin
			if (page_release) begin
				page_full[rel_page] <= 1'b0;	// Pages are released in fill order
				rel_page <= !rel_page;
			end
			if (wr_en && page_end) begin
				page_full[wr_page] <= 1'b1;
			end
		end
	end

	// No overwrite of a page the reader still owns
	a_no_write_full: assert property (
		@(posedge clk) disable iff (rst)
		wr_en |-> !page_full[wr_page]
	) else $error("write_ctrl wrote into a full page");

endmodule

// File: hw/bank_array.sv
`timescale 1ns/100ps

module bank_array import shuffle_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	// Write side with lanes already rotated onto banks
	input  logic           wr_en,
	input  bank_addr_t     wr_addr,
	input  lane_vec_t      wr_data,
	// Read request with per-bank addresses and the lane pattern
	input  logic           rd_en,
	input  bank_addr_vec_t rd_addr,
	input  bank_sel_vec_t  rd_pat,
	input  logic           fill_ok,	// Downstream can take a beat
	// Read stage output with lanes back in row order
	output lane_vec_t      rd_data,
	output logic           rd_vld
);

	logic          stage_en;	// Issue a read into the stage
	lane_vec_t     bank_q;	// Registered word of each bank
	bank_sel_vec_t pat_q;	// Pattern that goes with bank_q

	assign stage_en = rd_en && fill_ok;

	// ------------------------------------------------------------------------
	// Memory banks
	// ------------------------------------------------------------------------
	for (genvar b = 0; b < simd; b++) begin : g_bank
		bank_ram bank_ram_inst (
			.clk     (clk),
			.rst     (rst),
			.wr_en   (wr_en),
			.wr_addr (wr_addr),	// Same word address in every bank
			.wr_data (wr_data[b]),
			.rd_en   (stage_en),
			.rd_addr (rd_addr[b]),
			.rd_data (bank_q[b])
		);
	end

	// Pattern travels one cycle with the read
	always_ff @(posedge clk) begin
		if (stage_en) begin
			pat_q <= rd_pat;
		end
	end

	// Stage valid holds while downstream is full
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_vld <= 1'b0;
		end else if (fill_ok) begin
			rd_vld <= rd_en;	// Drops when the stage drains without a new read
		end
	end

	// Lane s picks the bank that the pattern names
	always_comb begin
		for (int s = 0; s < simd; s++) begin
			rd_data[s] = bank_q[pat_q[s]];
		end
	end

endmodule

// File: hw/bank_ram.sv
`timescale 1ns/100ps

module bank_ram import shuffle_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	// Write port, one word per accepted input beat
	input  logic       wr_en,
	input  bank_addr_t wr_addr,
	input  elem_t      wr_data,
	// Read port
	input  logic       rd_en,	// Low holds rd_data
	input  bank_addr_t rd_addr,
	output elem_t      rd_data
);

	// ------------------------------------------------------------------------
	// Storage, page 0 in the lower half and page 1 in the upper half
	// ------------------------------------------------------------------------
	elem_t mem [bank_depth];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read; value stays put while the pipeline is stalled
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];	// Old data on a same-address write
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	// Write counter must wrap at the end of page 1
	a_wr_addr_range: assert property (
		@(posedge clk) disable iff (rst)
		wr_en |-> (wr_addr < bank_addr_t'(bank_depth))
	) else $error("bank_ram write beyond bank_depth, addr %0d", wr_addr);

	// Read side is only steered into valid words too
	a_rd_addr_range: assert property (
		@(posedge clk) disable iff (rst)
		rd_en |-> (rd_addr < bank_addr_t'(bank_depth))
	) else $error("bank_ram read beyond bank_depth, addr %0d", rd_addr);

endmodule

// File: hw/shuffle_pkg.sv
package shuffle_pkg;

	// ------------------------------------------------------------------------
	// Matrix and datapath sizes
	// ------------------------------------------------------------------------
	localparam int unsigned elem_bits = 8;	// Element width
	localparam int unsigned rows = 8;	// Input matrix rows
	localparam int unsigned cols = 6;	// Input matrix columns
	localparam int unsigned simd = 4;	// Elements per beat, also the bank count

	// Euclid, iterative form
	function automatic int unsigned gcd(input int unsigned a, input int unsigned b);
		int unsigned x;
		int unsigned y;
		int unsigned t;
		x = a;
		y = b;
		while (y != 0) begin
			t = x % y;
			x = y;
			y = t;
		end
		return x;
	endfunction

	localparam int unsigned page_beats = rows * cols / simd;	// Beats per matrix
	localparam int unsigned bank_depth = 2 * page_beats;	// Two pages per bank
	localparam int unsigned wr_rotations = gcd(cols, simd);	// Distinct write offsets
	localparam int unsigned wr_rot_period = cols / wr_rotations;	// Beats per offset
	localparam int unsigned rd_rot_period = rows / simd;	// Row blocks per column

	typedef logic [elem_bits-1:0] elem_t;
	typedef elem_t [simd-1:0] lane_vec_t;	// One beat
	typedef logic [$clog2(bank_depth)-1:0] bank_addr_t;
	typedef logic [$clog2(simd)-1:0] bank_sel_t;
	typedef bank_sel_t [simd-1:0] bank_sel_vec_t;	// Bank per lane
	typedef bank_addr_t [simd-1:0] bank_addr_vec_t;	// Address per bank

	// ------------------------------------------------------------------------
	// Constant read patterns
	// ------------------------------------------------------------------------
	// Bank of each lane for the first block of column 0
	function automatic bank_sel_vec_t calc_rd_init_pat();
		bank_sel_vec_t pat;
		for (int s = 0; s < simd; s++) begin
			pat[s] = bank_sel_t'((s * cols + (s * wr_rotations) / simd) % simd);
		end
		return pat;
	endfunction

	function automatic bank_sel_vec_t invert_pat(input bank_sel_vec_t pat);
		bank_sel_vec_t rev;
		rev = '0;
		for (int b = 0; b < simd; b++) begin
			for (int s = 0; s < simd; s++) begin
				if (pat[s] == bank_sel_t'(b)) begin
					rev[b] = bank_sel_t'(s);	// Lane served by bank b
				end
			end
		end
		return rev;
	endfunction

	// Lane index map taking pattern of column c to column c+1
	function automatic bank_sel_vec_t calc_rev_perm_pat(input bank_sel_vec_t pat,
		input bank_sel_vec_t rev);
		bank_sel_vec_t perm;
		for (int s = 0; s < simd; s++) begin
			perm[s] = rev[(int'(pat[s]) + 1) % simd];
		end
		return perm;
	endfunction

	// Word of row s, column 0 within a page
	function automatic bank_addr_vec_t calc_rd_addr_init();
		bank_addr_vec_t addr;
		for (int s = 0; s < simd; s++) begin
			addr[s] = bank_addr_t'((s * cols) / simd);
		end
		return addr;
	endfunction

	localparam bank_sel_vec_t rd_init_pat = calc_rd_init_pat();
	localparam bank_sel_vec_t rev_rd_init_pat = invert_pat(rd_init_pat);
	localparam bank_sel_vec_t rev_rd_perm_pat = calc_rev_perm_pat(rd_init_pat, rev_rd_init_pat);
	localparam bank_addr_vec_t rd_addr_init = calc_rd_addr_init();

endpackage
